//--- byteMemCtrl.f
hdl/memPkg.sv
hdl/memArbiter.sv
hdl/fetchSequencer.sv
hdl/dataSequencer.sv
hdl/byteMemCtrl.sv
tests/byteRamModel.sv
tests/byteMemCtrl_assertions.sv
tests/byteMemCtrlTb.sv

//--- hdl/byteMemCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module byteMemCtrl
    import memPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    // fetch port
    input  logic              fetchEn,
    input  logic [ADDR_W-1:0] fetchAddr,
    output logic              fetchDone,
    output logic [WORD_W-1:0] fetchInst,

    // data port
    input  logic              dataEn,
    input  logic              dataLs,
    input  logic [LEN_W-1:0]  dataLen,
    input  logic [ADDR_W-1:0] dataAddr,
    input  logic [WORD_W-1:0] dataWdata,
    output logic              dataDone,
    output logic [WORD_W-1:0] dataRdata,

    output logic [1:0]        memOwner,

    // RAM port
    output logic [ADDR_W-1:0] memAddr,
    output logic              memWrite,
    output logic [BYTE_W-1:0] memWdata,
    input  logic [BYTE_W-1:0] memRdata
);

    logic              fetchGrant;
    logic              dataGrant;
    logic [ADDR_W-1:0] fetchBusAddr;
    logic [ADDR_W-1:0] dataBusAddr;
    logic              dataBusWrite;
    logic [BYTE_W-1:0] dataBusWdata;

    memArbiter i_memArbiter (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .fetchEn      (fetchEn),
        .dataEn       (dataEn),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .fetchBusAddr (fetchBusAddr),
        .dataBusAddr  (dataBusAddr),
        .dataBusWrite (dataBusWrite),
        .dataBusWdata (dataBusWdata),
        .fetchGrant   (fetchGrant),
        .dataGrant    (dataGrant),
        .memOwner     (memOwner),
        .memAddr      (memAddr),
        .memWrite     (memWrite),
        .memWdata     (memWdata)
    );

    fetchSequencer i_fetchSequencer (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .grant     (fetchGrant),
        .fetchAddr (fetchAddr),
        .memRdata  (memRdata),
        .busAddr   (fetchBusAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst)
    );

    dataSequencer i_dataSequencer (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .grant     (dataGrant),
        .dataLs    (dataLs),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .memRdata  (memRdata),
        .busAddr   (dataBusAddr),
        .busWrite  (dataBusWrite),
        .busWdata  (dataBusWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata)
    );

endmodule

`default_nettype wire

//--- hdl/dataSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dataSequencer
    import memPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              grant,

    input  logic              dataLs,
    input  logic [LEN_W-1:0]  dataLen,
    input  logic [ADDR_W-1:0] dataAddr,
    input  logic [WORD_W-1:0] dataWdata,
    input  logic [BYTE_W-1:0] memRdata,

    output logic [ADDR_W-1:0] busAddr,
    output logic              busWrite,
    output logic [BYTE_W-1:0] busWdata,
    output logic              dataDone,
    output logic [WORD_W-1:0] dataRdata
);

    logic [LEN_W-1:0] cnt;
    logic [1:0]       laneIdx;
    logic             active;
    logic             isLoad;
    logic             lastStore;
    logic             lastLoad;

    memWord_u loadWord;
    memWord_u nextWord;
    memWord_u storeWord;

    // grant stays high during the done cycle
    assign active    = grant && !dataDone;
    assign isLoad    = (dataLs == LS_LOAD);
    assign lastStore = (cnt == dataLen - LEN_W'(1));
    assign lastLoad  = (cnt == dataLen);

    assign busAddr = dataAddr + ADDR_W'(cnt);

    // store side, one lane per cycle low byte first
    assign storeWord = dataWdata;
    assign busWdata  = storeWord.bytes[cnt[1:0]];
    assign busWrite  = active && (dataLs == LS_STORE);

    // load side, lane of the address issued on the previous edge
    assign laneIdx = cnt[1:0] - 2'd1;

    always_comb begin
        nextWord = loadWord;
        nextWord.bytes[laneIdx] = memRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            dataDone <= 1'b0;
        end else if (rdy) begin
            dataDone <= 1'b0;
            if (active) begin
                if (isLoad ? lastLoad : lastStore) begin
                    cnt      <= '0;
                    dataDone <= 1'b1;
                end else begin
                    cnt <= cnt + LEN_W'(1);
                end
            end
        end
    end

    // cleared at the first edge so unread lanes come out zero
    always_ff @(posedge clk) begin
        if (rdy && active && isLoad) begin
            if (cnt == '0) begin
                loadWord <= '0;
            end else begin
                loadWord <= nextWord;
                if (lastLoad) begin
                    dataRdata <= nextWord.word;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetchSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetchSequencer
    import memPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              grant,

    input  logic [ADDR_W-1:0] fetchAddr,
    input  logic [BYTE_W-1:0] memRdata,

    output logic [ADDR_W-1:0] busAddr,
    output logic              fetchDone,
    output logic [WORD_W-1:0] fetchInst
);

    // counts rising edges since the grant was first seen
    logic [2:0] cnt;
    logic [1:0] laneIdx;
    logic       active;

    memWord_u instWord;
    memWord_u nextWord;

    // the done cycle still has grant high, so hold off a restart
    assign active  = grant && !fetchDone;
    assign laneIdx = cnt[1:0] - 2'd1;

    // byte returned now belongs to the address issued one edge ago
    always_comb begin
        nextWord = instWord;
        nextWord.bytes[laneIdx] = memRdata;
    end

    assign busAddr = fetchAddr + ADDR_W'(cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            fetchDone <= 1'b0;
        end else if (rdy) begin
            fetchDone <= 1'b0;
            if (active) begin
                if (cnt == 3'd4) begin
                    cnt       <= '0;
                    fetchDone <= 1'b1;
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && active && cnt != 3'd0) begin
            instWord <= nextWord;
            if (cnt == 3'd4) begin
                fetchInst <= nextWord.word;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter
    import memPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,

    input  logic              fetchEn,
    input  logic              dataEn,
    input  logic              fetchDone,
    input  logic              dataDone,

    input  logic [ADDR_W-1:0] fetchBusAddr,
    input  logic [ADDR_W-1:0] dataBusAddr,
    input  logic              dataBusWrite,
    input  logic [BYTE_W-1:0] dataBusWdata,

    output logic              fetchGrant,
    output logic              dataGrant,
    output logic [1:0]        memOwner,

    output logic [ADDR_W-1:0] memAddr,
    output logic              memWrite,
    output logic [BYTE_W-1:0] memWdata
);

    // owner register, data wins when both ask from idle
    always_ff @(posedge clk) begin
        if (rst) begin
            memOwner <= OWNER_NONE;
        end else if (rdy) begin
            case (memOwner)
                OWNER_NONE: begin
                    if (dataEn) begin
                        memOwner <= OWNER_DATA;
                    end else if (fetchEn) begin
                        memOwner <= OWNER_FETCH;
                    end
                end
                OWNER_DATA: begin
                    if (dataDone) begin
                        memOwner <= OWNER_NONE;
                    end
                end
                OWNER_FETCH: begin
                    if (fetchDone) begin
                        memOwner <= OWNER_NONE;
                    end
                end
                default: begin
                    memOwner <= OWNER_NONE;
                end
            endcase
        end
    end

    assign dataGrant  = (memOwner == OWNER_DATA);
    assign fetchGrant = (memOwner == OWNER_FETCH);

    // RAM port follows the owner
    assign memAddr  = dataGrant ? dataBusAddr : fetchBusAddr;
    assign memWdata = dataGrant ? dataBusWdata : '0;

    // no writes while frozen
    assign memWrite = dataGrant && dataBusWrite && rdy;

endmodule

`default_nettype wire

//--- hdl/memPkg.sv
`default_nettype none

package memPkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;
    localparam int LANES  = WORD_W / BYTE_W;

    // access length in bytes, legal values 1, 2 and 4
    localparam int LEN_W = 3;

    // load/store selector
    localparam logic LS_LOAD  = 1'b0;
    localparam logic LS_STORE = 1'b1;

    // who currently holds the RAM port
    localparam logic [1:0] OWNER_NONE  = 2'b00;
    localparam logic [1:0] OWNER_DATA  = 2'b01;
    localparam logic [1:0] OWNER_FETCH = 2'b10;

    // one word, or four byte lanes with lane 0 least significant
    typedef union packed {
        logic [WORD_W-1:0]                word;
        logic [LANES-1:0][BYTE_W-1:0]     bytes;
    } memWord_u;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f byteMemCtrl.f --top-module byteMemCtrlTb \
    -Mdir obj_dir -o byteMemCtrlSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/byteMemCtrlSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

//--- tests/byteMemCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none

module byteMemCtrlTb
    import memPkg::*;
();

    localparam int RESET_CYCLES = 4;
    localparam int WAIT_LIMIT   = 60;
    localparam int MIX_COUNT    = 40;
    // fetches, store/load, priority, stall, random mix
    localparam int TXN_TOTAL    = 3 + 9 + 2 + 9 + MIX_COUNT;

    logic              clk = 1'b0;
    logic              rst;
    logic              rdy;
    logic              fetchEn;
    logic [ADDR_W-1:0] fetchAddr;
    logic              fetchDone;
    logic [WORD_W-1:0] fetchInst;
    logic              dataEn;
    logic              dataLs;
    logic [LEN_W-1:0]  dataLen;
    logic [ADDR_W-1:0] dataAddr;
    logic [WORD_W-1:0] dataWdata;
    logic              dataDone;
    logic [WORD_W-1:0] dataRdata;
    logic [1:0]        memOwner;
    logic [ADDR_W-1:0] memAddr;
    logic              memWrite;
    logic [BYTE_W-1:0] memWdata;
    logic [BYTE_W-1:0] memRdata;

    logic [BYTE_W-1:0] shadow [256];
    logic              stallMode;

    always #5 clk = ~clk;

    byteMemCtrl i_byteMemCtrl (.*);

    byteRamModel i_byteRamModel (
        .clk   (clk),
        .en    (rdy),
        .addr  (memAddr),
        .write (memWrite),
        .wdata (memWdata),
        .rdata (memRdata)
    );

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input memWord_u got, input memWord_u exp);
        if (got.word !== exp.word) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got.word, exp.word);
            abortRun();
        end
    endtask

    task automatic checkOwner(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] memOwner: got 0x%h, expected 0x%h", got, exp);
            abortRun();
        end
    endtask

    // little-endian word with zeros above len bytes
    function automatic memWord_u shadowWord(input logic [ADDR_W-1:0] addr, input int len);
        memWord_u w;
        int       k;
        w.word = '0;
        for (k = 0; k < len; k++) begin
            w.bytes[k] = shadow[8'(addr + ADDR_W'(k))];
        end
        return w;
    endfunction

    task automatic storeShadow(input logic [ADDR_W-1:0] addr, input int len, input memWord_u w);
        int k;
        for (k = 0; k < len; k++) begin
            shadow[8'(addr + ADDR_W'(k))] = w.bytes[k];
        end
    endtask

    // random rdy level in stall mode
    task automatic nextCycle();
        @(negedge clk);
        if (stallMode) begin
            rdy = ($urandom_range(3) != 0);
        end
    endtask

    task automatic dataAccess(input logic ls, input int len, input logic [ADDR_W-1:0] addr,
                              input logic [WORD_W-1:0] wdata);
        int       n;
        memWord_u exp;
        exp       = shadowWord(addr, len);
        dataLs    = ls;
        dataLen   = LEN_W'(len);
        dataAddr  = addr;
        dataWdata = wdata;
        dataEn    = 1'b1;
        n = 0;
        do begin
            nextCycle();
            n++;
        end while (!dataDone && n < WAIT_LIMIT);
        if (!dataDone) begin
            $display("no done pulse came on the data port");
            abortRun();
        end
        dataEn = 1'b0;
        rdy    = 1'b1;
        if (ls == LS_STORE) begin
            storeShadow(addr, len, wdata);
        end else begin
            checkWord("dataRdata", dataRdata, exp);
        end
        @(negedge clk);
    endtask

    task automatic fetchAccess(input logic [ADDR_W-1:0] addr);
        int n;
        fetchAddr = addr;
        fetchEn   = 1'b1;
        n = 0;
        do begin
            nextCycle();
            n++;
        end while (!fetchDone && n < WAIT_LIMIT);
        if (!fetchDone) begin
            $display("no done pulse came on the fetch port");
            abortRun();
        end
        checkOwner(memOwner, OWNER_FETCH);
        checkWord("fetchInst", fetchInst, shadowWord(addr, 4));
        fetchEn = 1'b0;
        rdy     = 1'b1;
        @(negedge clk);
    endtask

    // store and fetch to one word requested in the same cycle
    task automatic priorityRace(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata);
        int   n;
        logic dataSeen;
        logic fetchSeen;
        dataLs    = LS_STORE;
        dataLen   = LEN_W'(4);
        dataAddr  = addr;
        dataWdata = wdata;
        fetchAddr = addr;
        dataEn    = 1'b1;
        fetchEn   = 1'b1;
        dataSeen  = 1'b0;
        fetchSeen = 1'b0;
        n = 0;
        nextCycle();
        checkOwner(memOwner, OWNER_DATA);
        while (!fetchSeen && n < WAIT_LIMIT) begin
            if (dataDone && !dataSeen) begin
                dataSeen = 1'b1;
                dataEn   = 1'b0;
                storeShadow(addr, 4, wdata);
            end
            if (fetchDone) begin
                if (!dataSeen) begin
                    $display("fetch finished before the data access that had priority");
                    abortRun();
                end
                fetchSeen = 1'b1;
                fetchEn   = 1'b0;
                checkWord("fetchInst", fetchInst, shadowWord(addr, 4));
            end else begin
                nextCycle();
                n++;
            end
        end
        if (!fetchSeen) begin
            $display("no done pulse came on the fetch port during the priority test");
            abortRun();
        end
        @(negedge clk);
    endtask

    initial begin
        repeat (RESET_CYCLES + 20 * TXN_TOTAL) @(posedge clk);
        $display("watchdog timeout, the tests did not finish in time");
        abortRun();
    end

    initial begin
        int                lens [3];
        int                i;
        int                k;
        int                kind;
        logic [ADDR_W-1:0] addr;
        memWord_u          ramWord;
        void'($urandom(32'hff08));
        lens      = '{1, 2, 4};
        rst       = 1'b1;
        rdy       = 1'b1;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataLs    = LS_LOAD;
        dataLen   = LEN_W'(1);
        dataAddr  = '0;
        dataWdata = '0;
        stallMode = 1'b0;
        for (i = 0; i < 256; i++) begin
            shadow[i] = 8'(i * 37 + (i >> 3)) ^ 8'hc5;
            i_byteRamModel.mem[i] = shadow[i];
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        fetchAccess(32'h00);
        fetchAccess(32'h14);
        fetchAccess(32'h7d);

        // full-word reload shows the neighbours were left alone
        for (i = 0; i < 3; i++) begin
            addr = ADDR_W'(32'h40 + 8 * i);
            dataAccess(LS_STORE, lens[i], addr, $urandom);
            dataAccess(LS_LOAD, lens[i], addr, '0);
            dataAccess(LS_LOAD, 4, addr, '0);
        end

        priorityRace(32'h90, $urandom);

        stallMode = 1'b1;
        for (i = 0; i < 3; i++) begin
            addr = ADDR_W'(32'ha0 + 4 * i);
            dataAccess(LS_STORE, lens[i], addr, $urandom);
            dataAccess(LS_LOAD, lens[i], addr, '0);
            fetchAccess(addr);
        end
        stallMode = 1'b0;
        rdy       = 1'b1;

        repeat (MIX_COUNT) begin
            kind = $urandom_range(2);
            addr = ADDR_W'($urandom_range(63));
            if (kind == 0) begin
                fetchAccess(addr);
            end else begin
                dataAccess(kind == 1 ? LS_LOAD : LS_STORE, lens[$urandom_range(2)], addr,
                           $urandom);
            end
        end

        // stray writes show up as RAM bytes that differ from the shadow
        for (i = 0; i < 256; i += 4) begin
            for (k = 0; k < LANES; k++) begin
                ramWord.bytes[k] = i_byteRamModel.mem[i + k];
            end
            checkWord("ram contents", ramWord, shadowWord(ADDR_W'(i), 4));
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/byteMemCtrl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module byteMemCtrlAssertions
    import memPkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       rdy,
    input logic       fetchDone,
    input logic       dataDone,
    input logic       memWrite,
    input logic [1:0] memOwner
);

    // a done that sees an active edge is cleared by it
    assert property (@(posedge clk) disable iff (rst) fetchDone && rdy |=> !fetchDone)
        else $error("fetchDone stayed high for more than one active cycle");
    assert property (@(posedge clk) disable iff (rst) dataDone && rdy |=> !dataDone)
        else $error("dataDone stayed high for more than one active cycle");

    assert property (@(posedge clk) disable iff (rst)
        memWrite |-> memOwner == OWNER_DATA && rdy)
        else $error("memWrite high without data ownership or while frozen");

    // owner moves only from idle or right after a done
    assert property (@(posedge clk) disable iff (rst)
        memOwner != $past(memOwner) |->
            $past(memOwner) == OWNER_NONE || $past(fetchDone || dataDone))
        else $error("bus owner changed in the middle of a transfer");

    assert property (@(posedge clk)
        rst |=> !fetchDone && !dataDone && !memWrite && memOwner == OWNER_NONE)
        else $error("outputs not at their reset values after reset");

endmodule

bind byteMemCtrl byteMemCtrlAssertions i_byteMemCtrlAssertions (
    .clk       (clk),
    .rst       (rst),
    .rdy       (rdy),
    .fetchDone (fetchDone),
    .dataDone  (dataDone),
    .memWrite  (memWrite),
    .memOwner  (memOwner)
);

`default_nettype wire

//--- tests/byteRamModel.sv
`timescale 1ns/1ps
`default_nettype none

module byteRamModel
    import memPkg::*;
(
    input  logic              clk,
    input  logic              en,
    input  logic [ADDR_W-1:0] addr,
    input  logic              write,
    input  logic [BYTE_W-1:0] wdata,
    output logic [BYTE_W-1:0] rdata
);

    // 256 bytes, upper address bits ignored
    logic [BYTE_W-1:0] mem [256];

    // frozen together with the controller, old byte returned on a write
    always @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr[7:0]];
            if (write) begin
                mem[addr[7:0]] = wdata;
            end
        end
    end

endmodule

`default_nettype wire
